/* src/mem_defines.svh */
// shared constants for the memory stage; CP0 numbers assume select 0, credits must fit in CREDIT_W
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// cp0 register numbers
`define CP0_BADVADDR 5'd8
`define CP0_STATUS   5'd12
`define CP0_CAUSE    5'd13
`define CP0_EPC      5'd14

// cause exception codes
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_NONE 5'd31  // no exception pending

`define EXC_VECTOR 32'h8000_0180  // single fixed vector, no boot vectors

`define KSEG0_BASE 32'h8000_0000
`define KSEG1_BASE 32'hA000_0000

`define DBUS_CREDITS 4
`define CREDIT_W     3

`endif

/* src/MemPkg.sv */
// shared types of the memory stage; MemOp encoding is internal and not a bus format
package MemPkg;

    typedef logic [31:0] Word;     // data or address word
    typedef logic [4:0]  RegAddr;  // gpr or cp0 register number
    typedef logic [3:0]  ByteEn;   // byte write strobe
    typedef logic [4:0]  ExcCode;  // cause.ExcCode field
    typedef logic [5:0]  IrqVec;   // hardware interrupt lines

    // memory operation carried down from decode
    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW
    } MemOp;

endpackage

/* src/MemStageReg.sv */
// execute-to-memory register; flush beats hold, payload fields are not reset
`timescale 1ns/1ps
`include "mem_defines.svh"

module MemStageReg (
    input  logic           clk,
    input  logic           rstN,
    input  logic           hold,
    input  logic           flush,
    input  logic           exValid,
    input  MemPkg::Word    exPc,
    input  MemPkg::Word    exAluOut,
    input  MemPkg::Word    exStoreData,
    input  MemPkg::MemOp   exMemOp,
    input  MemPkg::RegAddr exDst,
    input  logic           exRegWr,
    input  logic           exCp0Wr,
    input  logic           exCp0Rd,
    input  logic           exEret,
    input  MemPkg::ExcCode exExcCode,
    output logic           memValid,
    output MemPkg::Word    memPc,
    output MemPkg::Word    memAddr,
    output MemPkg::Word    memStoreData,
    output MemPkg::MemOp   memOp,
    output MemPkg::RegAddr memDst,
    output logic           memRegWrRaw,
    output logic           memCp0Wr,
    output logic           memCp0Rd,
    output logic           memEret,
    output MemPkg::ExcCode memExcIn
);
    import MemPkg::*;

    // control fields, cleared on reset and on flush
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN || flush) begin
            memValid    <= 1'b0;
            memOp       <= MEM_NONE;
            memRegWrRaw <= 1'b0;
            memCp0Wr    <= 1'b0;
            memCp0Rd    <= 1'b0;
            memEret     <= 1'b0;
            memExcIn    <= `EXC_NONE;
        end else if (!hold) begin
            memValid    <= exValid;
            memOp       <= exValid ? exMemOp : MEM_NONE;  // bubble carries no op
            memRegWrRaw <= exValid & exRegWr;
            memCp0Wr    <= exValid & exCp0Wr;
            memCp0Rd    <= exValid & exCp0Rd;
            memEret     <= exValid & exEret;
            memExcIn    <= exValid ? exExcCode : `EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            memPc        <= exPc;
            memAddr      <= exAluOut;
            memStoreData <= exStoreData;
            memDst       <= exDst;
        end
    end

endmodule

/* src/StoreAligner.sv */
// little-endian lane placement; misalignment is reported for loads and stores alike
`timescale 1ns/1ps

module StoreAligner (
    input  logic         clk,
    input  logic         rstN,
    input  MemPkg::MemOp memOp,
    input  MemPkg::Word  memAddr,
    input  MemPkg::Word  storeData,
    output MemPkg::ByteEn wstrb,
    output MemPkg::Word  wdata,
    output logic         misaligned,
    output logic         isStore
);
    import MemPkg::*;

    assign isStore = memOp inside {MEM_SB, MEM_SH, MEM_SW};

    always_comb begin
        wstrb = '0;
        wdata = storeData;
        case (memOp)
            MEM_SB: begin
                wstrb = 4'b0001 << memAddr[1:0];
                wdata = {4{storeData[7:0]}};  // byte copied to every lane
            end
            MEM_SH: begin
                wstrb = memAddr[1] ? 4'b1100 : 4'b0011;
                wdata = {2{storeData[15:0]}};
            end
            MEM_SW: wstrb = 4'b1111;
            default: ;
        endcase
    end

    always_comb begin
        case (memOp)
            MEM_LH, MEM_LHU, MEM_SH: misaligned = memAddr[0];
            MEM_LW, MEM_SW:          misaligned = |memAddr[1:0];
            default:                 misaligned = 1'b0;
        endcase
    end

    // a load must never reach the bus with a write strobe
    assert property (@(posedge clk) disable iff (!rstN)
        !(memOp inside {MEM_SB, MEM_SH, MEM_SW}) |-> (wstrb == '0));

endmodule

/* src/DataAddrXlate.sv */
// fixed segment mapping only; kseg2/kseg3 and kuseg are identity mapped, no TLB
`timescale 1ns/1ps
`include "mem_defines.svh"

module DataAddrXlate (
    input  MemPkg::Word vaddr,
    output MemPkg::Word paddr,
    output logic        cached
);

    always_comb begin
        case (vaddr[31:29])
            3'b100: begin  // kseg0
                paddr  = vaddr - `KSEG0_BASE;
                cached = 1'b1;
            end
            3'b101: begin  // kseg1, uncached window
                paddr  = vaddr - `KSEG1_BASE;
                cached = 1'b0;
            end
            default: begin
                paddr  = vaddr;
                cached = 1'b1;
            end
        endcase
    end

endmodule

/* src/Cp0Regs.sv */
// Status/Cause/EPC/BadVAddr only; IP7..2 follow irq one cycle late, EPC and BadVAddr not reset
`timescale 1ns/1ps
`include "mem_defines.svh"

module Cp0Regs (
    input  logic           clk,
    input  logic           rstN,
    input  MemPkg::IrqVec  irq,
    input  MemPkg::RegAddr rdAddr,
    input  logic           wrEn,
    input  MemPkg::RegAddr wrAddr,
    input  MemPkg::Word    wrData,
    input  logic           excTake,
    input  MemPkg::ExcCode excCodeIn,
    input  MemPkg::Word    excPc,
    input  MemPkg::Word    badVaddr,
    input  logic           badVaddrWr,
    input  logic           eretTake,
    output MemPkg::Word    rdData,
    output MemPkg::Word    status,
    output logic [7:0]     causeIp,
    output MemPkg::Word    epc
);
    import MemPkg::*;

    logic [7:0] statusIm;
    logic       statusExl;
    logic       statusIe;
    IrqVec      ipHw;      // cause bits 15:10
    logic [1:0] ipSw;      // software interrupts, cause bits 9:8
    ExcCode     causeExc;
    Word        badVaddrReg;

    assign status  = {16'b0, statusIm, 6'b0, statusExl, statusIe};
    assign causeIp = {ipHw, ipSw};

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ipHw      <= '0;
            ipSw      <= '0;
            statusIm  <= '0;
            statusExl <= 1'b0;
            statusIe  <= 1'b0;
            causeExc  <= '0;
        end else begin
            ipHw <= irq;  // sampled every cycle
            if (excTake) begin
                statusExl <= 1'b1;
                causeExc  <= excCodeIn;
            end else if (eretTake) begin
                statusExl <= 1'b0;
            end else if (wrEn && wrAddr == `CP0_STATUS) begin
                statusIm  <= wrData[15:8];
                statusExl <= wrData[1];
                statusIe  <= wrData[0];
            end else if (wrEn && wrAddr == `CP0_CAUSE) begin
                ipSw <= wrData[9:8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (excTake) begin
            epc <= excPc;
        end else if (wrEn && wrAddr == `CP0_EPC) begin
            epc <= wrData;
        end
        if (excTake && badVaddrWr) begin
            badVaddrReg <= badVaddr;  // address errors only
        end
    end

    always_comb begin
        case (rdAddr)
            `CP0_STATUS:   rdData = status;
            `CP0_CAUSE:    rdData = {16'b0, causeIp, 1'b0, causeExc, 2'b0};
            `CP0_EPC:      rdData = epc;
            `CP0_BADVADDR: rdData = badVaddrReg;
            default:       rdData = '0;
        endcase
    end

    // exception resolution must never pick both
    assert property (@(posedge clk) disable iff (!rstN) !(excTake && eretTake));

endmodule

/* src/ExceptionUnit.sv */
// priority is interrupt, earlier-stage fault, address error, then eret; one fixed vector
`timescale 1ns/1ps
`include "mem_defines.svh"

module ExceptionUnit (
    input  logic           memValid,
    input  MemPkg::ExcCode memExcIn,
    input  logic           misaligned,
    input  logic           isStore,
    input  logic           memEret,
    input  MemPkg::Word    status,
    input  logic [7:0]     causeIp,
    input  MemPkg::Word    epc,
    output logic           excTake,
    output logic           eretTake,
    output MemPkg::ExcCode excCode,
    output logic           excFlush,
    output MemPkg::Word    excTarget,
    output logic           badVaddrWr
);
    logic intPending;

    // IE set, EXL clear, some unmasked IP bit
    assign intPending = status[0] & ~status[1] & (|(causeIp & status[15:8]));

    always_comb begin
        excTake    = 1'b0;
        eretTake   = 1'b0;
        badVaddrWr = 1'b0;
        excCode    = `EXC_NONE;
        if (memValid) begin
            if (intPending) begin
                excTake = 1'b1;
                excCode = `EXC_INT;
            end else if (memExcIn != `EXC_NONE) begin
                excTake = 1'b1;
                excCode = memExcIn;  // fault from fetch/decode/execute
            end else if (misaligned) begin
                excTake    = 1'b1;
                badVaddrWr = 1'b1;
                excCode    = isStore ? `EXC_ADES : `EXC_ADEL;
            end else if (memEret) begin
                eretTake = 1'b1;
            end
        end
    end

    assign excFlush  = excTake | eretTake;
    assign excTarget = eretTake ? epc : `EXC_VECTOR;

endmodule

/* src/DataReqIssue.sv */
// credit flow only, no ready; bus must never return more credits than it was given
`timescale 1ns/1ps
`include "mem_defines.svh"

module DataReqIssue (
    input  logic          clk,
    input  logic          rstN,
    input  logic          memValid,
    input  MemPkg::MemOp  memOp,
    input  logic          suppress,
    input  MemPkg::ByteEn wstrb,
    input  MemPkg::Word   wdata,
    input  logic          isStore,
    input  MemPkg::Word   paddr,
    input  logic          cached,
    input  logic          dCredit,
    output logic          dReqValid,
    output logic          dReqWrite,
    output MemPkg::Word   dReqAddr,
    output MemPkg::ByteEn dReqWstrb,
    output MemPkg::Word   dReqWdata,
    output logic          dReqCached,
    output logic          stall
);
    import MemPkg::*;

    logic [`CREDIT_W-1:0] credits;
    logic                 wantReq;
    logic                 haveCredit;

    assign wantReq    = memValid && (memOp != MEM_NONE) && !suppress;
    assign haveCredit = (credits != '0);

    assign dReqValid  = wantReq & haveCredit;
    assign stall      = wantReq & ~haveCredit;  // hold the op until a credit is back
    assign dReqWrite  = dReqValid & isStore;
    assign dReqAddr   = paddr;
    assign dReqWstrb  = wstrb;
    assign dReqWdata  = wdata;
    assign dReqCached = cached;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            credits <= `CREDIT_W'(`DBUS_CREDITS);
        end else begin
            case ({dReqValid, dCredit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;  // idle, or consume and return cancel
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstN)
        credits <= `CREDIT_W'(`DBUS_CREDITS));
    assert property (@(posedge clk) disable iff (!rstN)
        dReqValid |-> haveCredit);

endmodule

/* src/MemStageTop.sv */
// memory stage without cache, TLB or load return; one instruction in flight in the stage
`timescale 1ns/1ps

module MemStageTop (
    input  logic           clk,
    input  logic           rstN,
    input  logic           exValid,
    input  MemPkg::Word    exPc,
    input  MemPkg::Word    exAluOut,
    input  MemPkg::Word    exStoreData,
    input  MemPkg::MemOp   exMemOp,
    input  MemPkg::RegAddr exDst,
    input  logic           exRegWr,
    input  logic           exCp0Wr,
    input  logic           exCp0Rd,
    input  logic           exEret,
    input  MemPkg::ExcCode exExcCode,
    input  logic           memHold,
    input  logic           memFlush,
    input  MemPkg::IrqVec  irq,
    input  logic           dCredit,
    output logic           dReqValid,
    output logic           dReqWrite,
    output MemPkg::Word    dReqAddr,
    output MemPkg::ByteEn  dReqWstrb,
    output MemPkg::Word    dReqWdata,
    output logic           dReqCached,
    output logic           memStall,
    output logic           excFlush,
    output MemPkg::ExcCode excCode,
    output MemPkg::Word    excTarget,
    output MemPkg::Word    epc,
    output logic           memValid,
    output MemPkg::RegAddr memDst,
    output logic           memRegWr,
    output MemPkg::Word    memResult
);
    import MemPkg::*;

    Word        memPc;
    Word        memAddr;
    Word        memStoreData;
    MemOp       memOp;
    logic       memRegWrRaw;
    logic       memCp0Wr;
    logic       memCp0Rd;
    logic       memEret;
    ExcCode     memExcIn;
    ByteEn      wstrb;
    Word        wdata;
    logic       misaligned;
    logic       isStore;
    Word        paddr;
    logic       cached;
    Word        cp0RdData;
    Word        status;
    logic [7:0] causeIp;
    logic       excTake;
    logic       eretTake;
    logic       badVaddrWr;

    assign memRegWr  = memRegWrRaw & ~excFlush;           // faulting op writes nothing
    assign memResult = memCp0Rd ? cp0RdData : memAddr;    // mfc0 or alu result

    MemStageReg uStageReg (
        .clk          (clk),
        .rstN         (rstN),
        .hold         (memHold | memStall),
        .flush        (memFlush),
        .exValid      (exValid),
        .exPc         (exPc),
        .exAluOut     (exAluOut),
        .exStoreData  (exStoreData),
        .exMemOp      (exMemOp),
        .exDst        (exDst),
        .exRegWr      (exRegWr),
        .exCp0Wr      (exCp0Wr),
        .exCp0Rd      (exCp0Rd),
        .exEret       (exEret),
        .exExcCode    (exExcCode),
        .memValid     (memValid),
        .memPc        (memPc),
        .memAddr      (memAddr),
        .memStoreData (memStoreData),
        .memOp        (memOp),
        .memDst       (memDst),
        .memRegWrRaw  (memRegWrRaw),
        .memCp0Wr     (memCp0Wr),
        .memCp0Rd     (memCp0Rd),
        .memEret      (memEret),
        .memExcIn     (memExcIn)
    );

    StoreAligner uAligner (
        .clk        (clk),
        .rstN       (rstN),
        .memOp      (memOp),
        .memAddr    (memAddr),
        .storeData  (memStoreData),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .misaligned (misaligned),
        .isStore    (isStore)
    );

    DataAddrXlate uXlate (
        .vaddr  (memAddr),
        .paddr  (paddr),
        .cached (cached)
    );

    // mtc0 moves rt, which travels on the store data path
    Cp0Regs uCp0 (
        .clk        (clk),
        .rstN       (rstN),
        .irq        (irq),
        .rdAddr     (memDst),
        .wrEn       (memCp0Wr & ~excFlush),
        .wrAddr     (memDst),
        .wrData     (memStoreData),
        .excTake    (excTake),
        .excCodeIn  (excCode),
        .excPc      (memPc),
        .badVaddr   (memAddr),
        .badVaddrWr (badVaddrWr),
        .eretTake   (eretTake),
        .rdData     (cp0RdData),
        .status     (status),
        .causeIp    (causeIp),
        .epc        (epc)
    );

    ExceptionUnit uExc (
        .memValid   (memValid),
        .memExcIn   (memExcIn),
        .misaligned (misaligned),
        .isStore    (isStore),
        .memEret    (memEret),
        .status     (status),
        .causeIp    (causeIp),
        .epc        (epc),
        .excTake    (excTake),
        .eretTake   (eretTake),
        .excCode    (excCode),
        .excFlush   (excFlush),
        .excTarget  (excTarget),
        .badVaddrWr (badVaddrWr)
    );

    // an externally held op must not reissue every cycle
    DataReqIssue uIssue (
        .clk        (clk),
        .rstN       (rstN),
        .memValid   (memValid),
        .memOp      (memOp),
        .suppress   (excFlush | memHold),
        .wstrb      (wstrb),
        .wdata      (wdata),
        .isStore    (isStore),
        .paddr      (paddr),
        .cached     (cached),
        .dCredit    (dCredit),
        .dReqValid  (dReqValid),
        .dReqWrite  (dReqWrite),
        .dReqAddr   (dReqAddr),
        .dReqWstrb  (dReqWstrb),
        .dReqWdata  (dReqWdata),
        .dReqCached (dReqCached),
        .stall      (memStall)
    );

endmodule

/* test/ClockGen.sv */
// 20 ns clock from time zero; rstN low for the first 4 rising edges, released 2 ns after the last
`timescale 1ns/1ps

module ClockGen (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (4) @(posedge clk);
        #2 rstN = 1'b1;  // clear of the edge
    end

endmodule

/* test/MemStageTb.sv */
// row r is driven 2 ns after an edge and checked 1 ns after the next; the bus never back-pressures
`timescale 1ns/1ps
`include "mem_defines.svh"

module MemStageTb;
    import MemPkg::*;

    // execute-side stimulus of one row
    typedef struct packed {
        logic   valid;
        Word    pc;
        Word    alu;
        Word    sdata;
        MemOp   op;
        RegAddr dst;
        logic   regWr;
        logic   cp0Wr;
        logic   cp0Rd;
        logic   eret;
        ExcCode excIn;
        IrqVec  irq;
        logic   flush;
        logic   credit;
    } Stim;

    // what the stage should show while that row sits in it
    typedef struct packed {
        logic   want;
        logic   req;
        logic   stall;
        logic   valid;
        logic   regWr;
        logic   write;
        Word    addr;
        ByteEn  strb;
        Word    wdata;
        logic   cached;
        logic   exc;
        ExcCode code;
        Word    target;
        Word    result;
        RegAddr dst;
        logic   epcKnown;
        Word    epc;
    } Expect;

    logic   clk, rstN;
    logic   exValid, exRegWr, exCp0Wr, exCp0Rd, exEret;
    Word    exPc, exAluOut, exStoreData;
    MemOp   exMemOp;
    RegAddr exDst;
    ExcCode exExcCode;
    logic   memHold, memFlush, dCredit;
    IrqVec  irq;
    logic   dReqValid, dReqWrite, dReqCached, memStall, excFlush, memValid, memRegWr;
    Word    dReqAddr, dReqWdata, excTarget, epc, memResult;
    ByteEn  dReqWstrb;
    ExcCode excCode;
    RegAddr memDst;

    Stim   stims[$];
    Expect exps[$];
    string names[$];
    Stim   st;
    Expect ex;
    Expect held;          // op kept in the stage while out of credit
    bit    autoRet;       // bus hands each credit back one row later
    bit    retPending;
    bit    stalled;
    bit    flushNext;
    bit    tableReady;
    int    modelCredits;  // credit count as the table builder sees it
    int    creditCnt;     // credit count tracked while the table runs
    Word   pcNext;
    Word   rngState;
    Word   epcModel;      // pc of the last exception taken
    bit    epcSet;

    ClockGen uClock (.clk(clk), .rstN(rstN));

    MemStageTop u_dut (.*);

    task automatic stopOnFailure();
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkWord(input string what, input Word expVal, input Word actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] %s: expected %h, actual %h", what, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic checkByteEn(input string what, input ByteEn expVal, input ByteEn actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] %s: expected %b, actual %b", what, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic checkExcCode(input string what, input ExcCode expVal, input ExcCode actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] %s: expected %0d, actual %0d", what, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic checkRegAddr(input string what, input RegAddr expVal, input RegAddr actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] %s: expected %0d, actual %0d", what, expVal, actVal);
            stopOnFailure();
        end
    endtask

    task automatic checkBit(input string what, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] %s: expected %b, actual %b", what, expVal, actVal);
            stopOnFailure();
        end
    endtask

    // xorshift32
    function automatic Word nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic clearRow();
        st = '0;
        st.op = MEM_NONE;
        st.excIn = `EXC_NONE;
        st.pc = pcNext;
        ex = '0;
        ex.code = `EXC_NONE;
    endtask

    // byte or halfword copied into every little-endian lane
    task automatic expectLanes(input MemOp op, input Word addr, input Word data);
        ex.strb = 4'b0000;
        ex.wdata = data;
        if (op == MEM_SB) begin
            ex.strb = ByteEn'(1) << addr[1:0];
            ex.wdata = {4{data[7:0]}};
        end else if (op == MEM_SH) begin
            ex.strb = addr[1] ? 4'b1100 : 4'b0011;
            ex.wdata = {2{data[15:0]}};
        end else if (op == MEM_SW) begin
            ex.strb = 4'b1111;
        end
    endtask

    task automatic expectMapping(input Word addr);
        if (addr >= `KSEG1_BASE && addr < 32'hC000_0000) begin
            ex.addr = addr - `KSEG1_BASE;
            ex.cached = 1'b0;
        end else if (addr >= `KSEG0_BASE && addr < `KSEG1_BASE) begin
            ex.addr = addr - `KSEG0_BASE;
            ex.cached = 1'b1;
        end else begin
            ex.addr = addr;  // kuseg and kseg2/3 untouched
            ex.cached = 1'b1;
        end
    endtask

    // credit model decides whether the row's op issues or stalls
    task automatic pushRow(input string name);
        if (flushNext) begin
            st.flush = 1'b1;
            ex = '0;
            ex.code = `EXC_NONE;
            flushNext = 1'b0;
        end
        ex.dst = st.dst;
        if (stalled) ex = held;
        ex.epcKnown = epcSet;
        ex.epc = epcModel;
        if (ex.exc && ex.code != `EXC_NONE) begin
            epcModel = st.pc;  // recorded at the edge after the fault
            epcSet = 1'b1;
        end
        st.credit = st.credit | (autoRet & retPending);
        modelCredits = modelCredits + st.credit;
        ex.req = ex.want && modelCredits != 0;
        ex.stall = ex.want && modelCredits == 0;
        if (ex.req) modelCredits = modelCredits - 1;
        retPending = ex.req;
        stalled = ex.stall;
        held = ex;
        stims.push_back(st);
        exps.push_back(ex);
        names.push_back(name);
        pcNext = pcNext + 4;
    endtask

    task automatic memRow(input string name, input MemOp op, input Word addr, input Word data,
                          input logic regWr);
        logic store;
        logic misal;
        clearRow();
        st.valid = 1'b1;
        st.alu = addr;
        st.sdata = data;
        st.op = op;
        st.dst = 5'd2;
        st.regWr = regWr;
        store = op inside {MEM_SB, MEM_SH, MEM_SW};
        misal = ((op == MEM_LH || op == MEM_LHU || op == MEM_SH) && addr[0])
             || ((op == MEM_LW || op == MEM_SW) && addr[1:0] != 2'b00);
        ex.valid = 1'b1;
        ex.result = addr;
        ex.write = store;
        expectLanes(op, addr, data);
        expectMapping(addr);
        if (misal) begin
            ex.exc = 1'b1;
            ex.code = store ? `EXC_ADES : `EXC_ADEL;
            ex.target = `EXC_VECTOR;
        end else begin
            ex.want = 1'b1;
            ex.regWr = regWr;
        end
        pushRow(name);
    endtask

    task automatic aluRow(input string name, input Word result, input IrqVec lines,
                          input logic expInt);
        clearRow();
        st.valid = 1'b1;
        st.alu = result;
        st.dst = 5'd3;
        st.regWr = 1'b1;
        st.irq = lines;
        ex.valid = 1'b1;
        ex.result = result;
        if (expInt) begin
            ex.exc = 1'b1;
            ex.code = `EXC_INT;
            ex.target = `EXC_VECTOR;
        end else begin
            ex.regWr = 1'b1;
        end
        pushRow(name);
    endtask

    task automatic mfc0Row(input string name, input RegAddr cp0Reg, input Word expVal);
        clearRow();
        st.valid = 1'b1;
        st.dst = cp0Reg;
        st.cp0Rd = 1'b1;
        st.regWr = 1'b1;
        ex.valid = 1'b1;
        ex.regWr = 1'b1;
        ex.result = expVal;
        pushRow(name);
    endtask

    task automatic mtc0Row(input string name, input RegAddr cp0Reg, input Word value);
        clearRow();
        st.valid = 1'b1;
        st.dst = cp0Reg;
        st.cp0Wr = 1'b1;
        st.sdata = value;  // rt rides on the store data path
        ex.valid = 1'b1;
        pushRow(name);
    endtask

    task automatic eretRow(input string name, input Word expTarget);
        clearRow();
        st.valid = 1'b1;
        st.eret = 1'b1;
        ex.valid = 1'b1;
        ex.exc = 1'b1;
        ex.target = expTarget;
        pushRow(name);
    endtask

    task automatic bubbleRow(input string name, input IrqVec lines, input logic credit);
        clearRow();
        st.irq = lines;
        st.credit = credit;
        pushRow(name);
    endtask

    task automatic buildTable();
        Word base;
        Word faultPc;
        int  off;
        for (off = 0; off < 4; off++) begin
            base = 32'h8000_0000 | (nextRand() & 32'h1FFF_FFFC);
            memRow($sformatf("sb kseg0 +%0d", off), MEM_SB, base + off, nextRand(), 1'b0);
        end
        for (off = 0; off < 4; off = off + 2) begin
            base = 32'hA000_0000 | (nextRand() & 32'h1FFF_FFFC);
            memRow($sformatf("sh kseg1 +%0d", off), MEM_SH, base + off, nextRand(), 1'b0);
        end
        memRow("sw kuseg", MEM_SW, nextRand() & 32'h7FFF_FFFC, nextRand(), 1'b0);
        memRow("lw kseg1", MEM_LW, 32'hA000_0000 | (nextRand() & 32'h1FFF_FFFC), 0, 1'b1);
        memRow("lb kseg0 +3", MEM_LB, 32'h8000_0003 | (nextRand() & 32'h1FFF_FFFC), 0, 1'b1);
        memRow("lhu kuseg +2", MEM_LHU, 32'h0000_0002 | (nextRand() & 32'h7FFF_FFFC), 0, 1'b1);

        // address errors and then the CP0 records they leave
        base = 32'h8000_0002 | (nextRand() & 32'h1FFF_FFFC);
        faultPc = pcNext;
        memRow("lw misaligned", MEM_LW, base, 0, 1'b1);
        mfc0Row("mfc0 EPC after AdEL", `CP0_EPC, faultPc);
        mfc0Row("mfc0 BadVAddr after AdEL", `CP0_BADVADDR, base);
        base = 32'hA000_0003 | (nextRand() & 32'h1FFF_FFFC);
        faultPc = pcNext;
        memRow("sw misaligned", MEM_SW, base, nextRand(), 1'b0);
        mfc0Row("mfc0 EPC after AdES", `CP0_EPC, faultPc);
        mfc0Row("mfc0 BadVAddr after AdES", `CP0_BADVADDR, base);

        // irq0 lands on IP2 which IM2 (status bit 10) unmasks
        mtc0Row("mtc0 Status IE IM2", `CP0_STATUS, 32'h0000_0401);
        bubbleRow("raise irq0", 6'b000001, 1'b0);
        faultPc = pcNext;
        aluRow("interrupted addu", 32'h1234_5678, 6'b000001, 1'b1);
        mfc0Row("mfc0 Status EXL set", `CP0_STATUS, 32'h0000_0403);
        eretRow("eret", faultPc);
        mfc0Row("mfc0 Status EXL clear", `CP0_STATUS, 32'h0000_0401);

        // credit flow with the bus holding every credit
        bubbleRow("drain returns", 6'b0, 1'b0);
        autoRet = 1'b0;
        memRow("faulting lw", MEM_LW, 32'h0000_1001, 0, 1'b1);
        flushNext = 1'b1;
        memRow("flushed lw", MEM_LW, 32'h0000_1000, 0, 1'b1);
        memRow("credit op 1 sw", MEM_SW, 32'h8000_2000, nextRand(), 1'b0);
        memRow("credit op 2 sb", MEM_SB, 32'hA000_2001, nextRand(), 1'b0);
        memRow("credit op 3 lw", MEM_LW, 32'h0000_2004, 0, 1'b1);
        memRow("credit op 4 sh", MEM_SH, 32'h8000_2006, nextRand(), 1'b0);
        memRow("credit op 5 stalls", MEM_SW, 32'h8000_2008, nextRand(), 1'b0);
        bubbleRow("one credit back", 6'b0, 1'b1);
        bubbleRow("idle", 6'b0, 1'b0);
        tableReady = 1'b1;
    endtask

    task automatic driveIdle();
        exValid = 1'b0;
        exPc = '0;
        exAluOut = '0;
        exStoreData = '0;
        exMemOp = MEM_NONE;
        exDst = '0;
        exRegWr = 1'b0;
        exCp0Wr = 1'b0;
        exCp0Rd = 1'b0;
        exEret = 1'b0;
        exExcCode = `EXC_NONE;
        memHold = 1'b0;
        memFlush = 1'b0;
        irq = '0;
        dCredit = 1'b0;
    endtask

    task automatic driveRow(input Stim s);
        exValid = s.valid;
        exPc = s.pc;
        exAluOut = s.alu;
        exStoreData = s.sdata;
        exMemOp = s.op;
        exDst = s.dst;
        exRegWr = s.regWr;
        exCp0Wr = s.cp0Wr;
        exCp0Rd = s.cp0Rd;
        exEret = s.eret;
        exExcCode = s.excIn;
        memFlush = s.flush;
        irq = s.irq;
        dCredit = s.credit;
    endtask

    task automatic checkRow(input int k);
        Expect e;
        string n;
        e = exps[k];
        n = names[k];
        if (dReqValid === 1'b1 && creditCnt == 0) begin
            $display("%s: request sent while the bus had no credit left", n);
            stopOnFailure();
        end
        checkBit({n, " dReqValid"}, e.req, dReqValid);
        checkBit({n, " memStall"}, e.stall, memStall);
        checkBit({n, " memValid"}, e.valid, memValid);
        checkBit({n, " memRegWr"}, e.regWr, memRegWr);
        checkBit({n, " excFlush"}, e.exc, excFlush);
        checkExcCode({n, " excCode"}, e.code, excCode);
        if (e.exc) checkWord({n, " excTarget"}, e.target, excTarget);
        if (e.req) begin
            checkBit({n, " dReqWrite"}, e.write, dReqWrite);
            checkWord({n, " dReqAddr"}, e.addr, dReqAddr);
            checkByteEn({n, " dReqWstrb"}, e.strb, dReqWstrb);
            checkBit({n, " dReqCached"}, e.cached, dReqCached);
            if (e.write) checkWord({n, " dReqWdata"}, e.wdata, dReqWdata);
        end
        if (e.valid) begin
            checkWord({n, " memResult"}, e.result, memResult);
            checkRegAddr({n, " memDst"}, e.dst, memDst);
        end
        if (e.epcKnown) checkWord({n, " epc"}, e.epc, epc);
        creditCnt = creditCnt - int'(dReqValid === 1'b1);
    endtask

    initial begin
        int i;
        driveIdle();
        rngState = 32'd71084;
        pcNext = 32'h0040_0000;
        modelCredits = `DBUS_CREDITS;
        autoRet = 1'b1;
        retPending = 1'b0;
        stalled = 1'b0;
        flushNext = 1'b0;
        tableReady = 1'b0;
        epcModel = '0;
        epcSet = 1'b0;
        buildTable();
        wait (rstN === 1'b1);
        #1;
        checkBit("reset dReqValid", 1'b0, dReqValid);
        checkBit("reset excFlush", 1'b0, excFlush);
        checkBit("reset memRegWr", 1'b0, memRegWr);
        checkBit("reset memValid", 1'b0, memValid);
        checkBit("reset memStall", 1'b0, memStall);
        checkExcCode("reset excCode", `EXC_NONE, excCode);
        creditCnt = `DBUS_CREDITS;
        for (i = 0; i <= stims.size(); i++) begin
            @(posedge clk);
            #1;
            if (i > 0) checkRow(i - 1);
            #1;
            if (i < stims.size()) begin
                driveRow(stims[i]);
                creditCnt = creditCnt + stims[i].credit;  // back at the next edge
            end else begin
                driveIdle();
            end
        end
        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        wait (tableReady);
        repeat ((stims.size() + 20) * 4) #20;
        $display("watchdog expired before every table row was checked");
        stopOnFailure();
    end

endmodule

/* verilog.f */
+incdir+src
src/MemPkg.sv
src/MemStageReg.sv
src/StoreAligner.sv
src/DataAddrXlate.sv
src/Cp0Regs.sv
src/ExceptionUnit.sv
src/DataReqIssue.sv
src/MemStageTop.sv
test/ClockGen.sv
test/MemStageTb.sv

/* Bender.yml */
package:
  name: mem_stage

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/MemPkg.sv
      - src/MemStageReg.sv
      - src/StoreAligner.sv
      - src/DataAddrXlate.sv
      - src/Cp0Regs.sv
      - src/ExceptionUnit.sv
      - src/DataReqIssue.sv
      - src/MemStageTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/ClockGen.sv
      - test/MemStageTb.sv
